/* verilog/isa_pkg.sv */
/*
 * instruction set definitions
 *   word, instruction, register index, immediate and address types
 *   register file and data memory sizes
 *   instruction field positions and the opcode enum
 */
package isa_pkg;

    typedef logic [15:0] word_t;      // data word
    typedef logic [15:0] instr_t;     // raw instruction word
    typedef logic [2:0]  reg_idx_t;   // register file index
    typedef logic [7:0]  imm_t;       // LBI / SLBI immediate
    typedef logic [3:0]  mem_addr_t;  // data memory address, low bits of rs

    localparam int NUM_REGS   = 8;
    localparam int DMEM_WORDS = 16;

    // field positions, each field read upward from its lsb
    localparam int OPC_LSB = 12;  // 4 bits
    localparam int RD_LSB  = 9;   // 3 bits
    localparam int RS_LSB  = 6;   // 3 bits
    localparam int RT_LSB  = 3;   // 3 bits
    localparam int IMM_LSB = 0;   // 8 bits, overlaps rs and rt

    // opcode 0 and 11..15 decode as no-op
    typedef enum logic [3:0] {
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,   // rs - rt
        OP_AND  = 4'd3,
        OP_XOR  = 4'd4,
        OP_SEQ  = 4'd5,
        OP_SLT  = 4'd6,   // signed compare
        OP_LBI  = 4'd7,
        OP_SLBI = 4'd8,   // source register sits in the rd field
        OP_LD   = 4'd9,
        OP_ST   = 4'd10
    } op_e;

endpackage

/* verilog/pipe_pkg.sv */
/*
 * pipeline control definitions
 *   write-select codes for picking a stage result
 *   ALU and set-compare operation codes carried with each instruction
 */
package pipe_pkg;

    // result select, same code points as the older core
    // codes 2, 6 and 7 pick zero
    typedef enum logic [2:0] {
        SEL_ALU  = 3'd0,
        SEL_MEM  = 3'd1,
        SEL_SET  = 3'd3,
        SEL_LBI  = 3'd4,
        SEL_SLBI = 3'd5
    } wr_sel_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_e;

    typedef enum logic {
        SET_EQ = 1'b0,
        SET_LT = 1'b1   // signed less-than
    } set_op_e;

endpackage

/* verilog/stage_if.sv */
/*
 * stage_if
 *   contents of one pipeline stage register
 *   src modport for the owning stage, dst for readers
 */
`timescale 1ns/1ps

interface stage_if import isa_pkg::*, pipe_pkg::*; ();
    logic     valid;        // slot holds an instruction
    logic     wr_en;        // instruction writes rd
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    logic     has_rt;       // rt is a real source
    logic     is_ld;
    logic     is_st;
    wr_sel_e  wr_sel;
    alu_op_e  alu_op;
    set_op_e  set_op;
    word_t    rs_data;      // operand words, forwarded once past execute
    word_t    rt_data;
    word_t    alu_result;
    word_t    set_result;
    word_t    lbi_result;   // in de_ex this is the sign-extended immediate
    word_t    slbi_result;
    word_t    mem_result;

    modport src (
        output valid, wr_en, rd, rs, rt, has_rt, is_ld, is_st, wr_sel, alu_op, set_op,
        output rs_data, rt_data, alu_result, set_result, lbi_result, slbi_result, mem_result
    );

    modport dst (
        input valid, wr_en, rd, rs, rt, has_rt, is_ld, is_st, wr_sel, alu_op, set_op,
        input rs_data, rt_data, alu_result, set_result, lbi_result, slbi_result, mem_result
    );
endinterface

/* verilog/decode_stage.sv */
/*
 * decode_stage
 *   opcode decode into pipeline control
 *   8-entry register file with writeback read bypass
 *   load-use stall and the decode/execute register
 */
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     stall,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    stage_if.src     de_ex
);
    op_e      op;
    reg_idx_t rd_idx;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    imm_t     imm;
    word_t    rs_val;
    word_t    rt_val;
    logic     accept;
    logic     dec_wr_en;
    logic     dec_has_rt;
    logic     dec_is_ld;
    logic     dec_is_st;
    wr_sel_e  dec_wr_sel;
    alu_op_e  dec_alu_op;
    set_op_e  dec_set_op;
    word_t    rf [NUM_REGS];

    assign op     = op_e'(instr[OPC_LSB +: 4]);
    assign rd_idx = instr[RD_LSB +: 3];
    assign rt_idx = instr[RT_LSB +: 3];
    assign imm    = instr[IMM_LSB +: 8];
    // SLBI shifts its own destination, so it reads the rd field
    assign rs_idx = (op == OP_SLBI) ? instr[RD_LSB +: 3] : instr[RS_LSB +: 3];

    always_comb begin
        dec_wr_en  = 1'b0;     // unknown opcodes fall through as no-op
        dec_has_rt = 1'b0;
        dec_is_ld  = 1'b0;
        dec_is_st  = 1'b0;
        dec_wr_sel = SEL_ALU;
        dec_alu_op = ALU_ADD;
        dec_set_op = SET_EQ;
        case (op)
            OP_ADD:  begin dec_wr_en = 1'b1; dec_has_rt = 1'b1; end
            OP_SUB:  begin dec_wr_en = 1'b1; dec_has_rt = 1'b1; dec_alu_op = ALU_SUB; end
            OP_AND:  begin dec_wr_en = 1'b1; dec_has_rt = 1'b1; dec_alu_op = ALU_AND; end
            OP_XOR:  begin dec_wr_en = 1'b1; dec_has_rt = 1'b1; dec_alu_op = ALU_XOR; end
            OP_SEQ:  begin dec_wr_en = 1'b1; dec_has_rt = 1'b1; dec_wr_sel = SEL_SET; end
            OP_SLT: begin
                dec_wr_en  = 1'b1;
                dec_has_rt = 1'b1;
                dec_wr_sel = SEL_SET;
                dec_set_op = SET_LT;
            end
            OP_LBI:  begin dec_wr_en = 1'b1; dec_wr_sel = SEL_LBI; end
            OP_SLBI: begin dec_wr_en = 1'b1; dec_wr_sel = SEL_SLBI; end
            OP_LD:   begin dec_wr_en = 1'b1; dec_is_ld = 1'b1; dec_wr_sel = SEL_MEM; end
            OP_ST:   begin dec_has_rt = 1'b1; dec_is_st = 1'b1; end
            default: ;
        endcase
    end

    // writeback lands at the end of this cycle, bypass it so the read is current
    assign rs_val = (wb_valid && wb_rd == rs_idx) ? wb_data : rf[rs_idx];
    assign rt_val = (wb_valid && wb_rd == rt_idx) ? wb_data : rf[rt_idx];

    // load in execute, its data is not there until the mem/wb register
    assign stall  = instr_valid && de_ex.is_ld
                    && (de_ex.rd == rs_idx || (dec_has_rt && de_ex.rd == rt_idx));
    assign accept = instr_valid && !stall;   // otherwise a bubble goes down

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_valid) begin
            rf[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            de_ex.valid <= 1'b0;
            de_ex.wr_en <= 1'b0;
            de_ex.is_ld <= 1'b0;
            de_ex.is_st <= 1'b0;
        end else begin
            de_ex.valid <= accept;
            de_ex.wr_en <= accept && dec_wr_en;
            de_ex.is_ld <= accept && dec_is_ld;
            de_ex.is_st <= accept && dec_is_st;
        end
    end

    always_ff @(posedge clk) begin
        de_ex.rd         <= rd_idx;
        de_ex.rs         <= rs_idx;
        de_ex.rt         <= rt_idx;
        de_ex.has_rt     <= dec_has_rt;
        de_ex.wr_sel     <= dec_wr_sel;
        de_ex.alu_op     <= dec_alu_op;
        de_ex.set_op     <= dec_set_op;
        de_ex.rs_data    <= rs_val;
        de_ex.rt_data    <= rt_val;
        de_ex.lbi_result <= {{8{imm[7]}}, imm};   // sign-extended, SLBI uses low byte
    end

    // results are produced further down the pipe
    assign de_ex.alu_result  = '0;
    assign de_ex.set_result  = '0;
    assign de_ex.slbi_result = '0;
    assign de_ex.mem_result  = '0;

    // a writeback only ever comes from a write-enabled slot that left decode two cycles back
    a_wb_has_wr_en: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> $past(de_ex.wr_en, 2) && $past(de_ex.rd, 2) == wb_rd);

endmodule

/* verilog/forward.sv */
/*
 * forward
 *   hazard detection for the execute-stage source operands
 *   store-data forward from writeback into the memory stage
 *   per-stage result selection through the write-select code
 */
`timescale 1ns/1ps

module forward import isa_pkg::*, pipe_pkg::*; (
    stage_if.dst  ex_mem,
    stage_if.dst  mem_wb,
    stage_if.dst  de_ex,
    output logic  ex_fwd_rs,        // rs into execute from ex/mem
    output logic  ex_fwd_rt,        // rt into execute from ex/mem
    output logic  mem_fwd_rs,       // rs into execute from mem/wb
    output logic  mem_fwd_rt,       // rt into execute from mem/wb
    output logic  mem_to_mem_fwd,   // store data into memory from mem/wb
    output word_t ex_data,
    output word_t mem_data
);

    function automatic word_t pick_result(
        input wr_sel_e sel,
        input word_t   alu,
        input word_t   mem,
        input word_t   set,
        input word_t   lbi,
        input word_t   slbi
    );
        word_t res;
        case (sel)
            SEL_ALU:  res = alu;
            SEL_MEM:  res = mem;
            SEL_SET:  res = set;
            SEL_LBI:  res = lbi;
            SEL_SLBI: res = slbi;
            default:  res = '0;   // unused codes
        endcase
        return res;
    endfunction

    // nearest producer first
    // a load sitting in ex/mem never matches, the stall keeps its consumer back
    assign ex_fwd_rs = ex_mem.wr_en && (ex_mem.rd == de_ex.rs);
    assign ex_fwd_rt = ex_mem.wr_en && de_ex.has_rt && (ex_mem.rd == de_ex.rt);

    // older producer, only when ex/mem does not already cover the operand
    assign mem_fwd_rs = mem_wb.wr_en && (mem_wb.rd == de_ex.rs) && !ex_fwd_rs;
    assign mem_fwd_rt = mem_wb.wr_en && de_ex.has_rt && (mem_wb.rd == de_ex.rt)
                        && !ex_fwd_rt;

    // stores in execute already take rt through the two paths above
    assign mem_to_mem_fwd = mem_wb.wr_en && ex_mem.is_st && (mem_wb.rd == ex_mem.rt);

    // ex/mem carries no memory data yet, its mem_result is zero
    assign ex_data  = pick_result(ex_mem.wr_sel, ex_mem.alu_result, ex_mem.mem_result,
                                  ex_mem.set_result, ex_mem.lbi_result, ex_mem.slbi_result);
    assign mem_data = pick_result(mem_wb.wr_sel, mem_wb.alu_result, mem_wb.mem_result,
                                  mem_wb.set_result, mem_wb.lbi_result, mem_wb.slbi_result);

endmodule

/* verilog/execute_stage.sv */
/*
 * execute_stage
 *   operand select between register read and forwarded results
 *   ALU, set compare, LBI and SLBI results
 *   execute/memory register
 */
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    stage_if.dst  de_ex,
    stage_if.src  ex_mem,
    input  logic  ex_fwd_rs,
    input  logic  ex_fwd_rt,
    input  logic  mem_fwd_rs,
    input  logic  mem_fwd_rt,
    input  word_t ex_data,
    input  word_t mem_data
);
    word_t rs_op;
    word_t rt_op;
    word_t alu_res;
    word_t slbi_res;
    logic  set_bit;

    // forward data wins over the value read in decode
    assign rs_op = ex_fwd_rs  ? ex_data  :
                   mem_fwd_rs ? mem_data : de_ex.rs_data;
    assign rt_op = ex_fwd_rt  ? ex_data  :
                   mem_fwd_rt ? mem_data : de_ex.rt_data;

    always_comb begin
        case (de_ex.alu_op)
            ALU_ADD: alu_res = rs_op + rt_op;
            ALU_SUB: alu_res = rs_op - rt_op;
            ALU_AND: alu_res = rs_op & rt_op;
            default: alu_res = rs_op ^ rt_op;   // ALU_XOR
        endcase
    end

    assign set_bit  = (de_ex.set_op == SET_LT) ? ($signed(rs_op) < $signed(rt_op))
                                               : (rs_op == rt_op);
    assign slbi_res = {rs_op[7:0], de_ex.lbi_result[7:0]};   // rs << 8 | imm

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
            ex_mem.wr_en <= 1'b0;
            ex_mem.is_ld <= 1'b0;
            ex_mem.is_st <= 1'b0;
        end else begin
            ex_mem.valid <= de_ex.valid;
            ex_mem.wr_en <= de_ex.valid && de_ex.wr_en;
            ex_mem.is_ld <= de_ex.valid && de_ex.is_ld;
            ex_mem.is_st <= de_ex.valid && de_ex.is_st;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.rd          <= de_ex.rd;
        ex_mem.rs          <= de_ex.rs;
        ex_mem.rt          <= de_ex.rt;
        ex_mem.has_rt      <= de_ex.has_rt;
        ex_mem.wr_sel      <= de_ex.wr_sel;
        ex_mem.alu_op      <= de_ex.alu_op;
        ex_mem.set_op      <= de_ex.set_op;
        ex_mem.rs_data     <= rs_op;   // memory address
        ex_mem.rt_data     <= rt_op;   // store data
        ex_mem.alu_result  <= alu_res;
        ex_mem.set_result  <= word_t'(set_bit);
        ex_mem.lbi_result  <= de_ex.lbi_result;
        ex_mem.slbi_result <= slbi_res;
    end

    assign ex_mem.mem_result = '0;   // filled in by the memory stage

endmodule

/* verilog/memory_stage.sv */
/*
 * memory_stage
 *   16-word data memory addressed by the low bits of rs
 *   store data with forward from writeback, load read
 *   memory/writeback register
 */
`timescale 1ns/1ps

module memory_stage import isa_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    stage_if.dst  ex_mem,
    stage_if.src  mem_wb,
    input  logic  mem_to_mem_fwd,
    input  word_t mem_data
);
    word_t     dmem [DMEM_WORDS];
    mem_addr_t addr;
    word_t     st_data;
    logic      do_store;

    assign addr     = ex_mem.rs_data[3:0];
    assign st_data  = mem_to_mem_fwd ? mem_data : ex_mem.rt_data;
    assign do_store = ex_mem.valid && ex_mem.is_st;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (do_store) begin
            dmem[addr] <= st_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
            mem_wb.wr_en <= 1'b0;
            mem_wb.is_ld <= 1'b0;
            mem_wb.is_st <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
            mem_wb.wr_en <= ex_mem.valid && ex_mem.wr_en;
            mem_wb.is_ld <= ex_mem.valid && ex_mem.is_ld;
            mem_wb.is_st <= do_store;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb.rd          <= ex_mem.rd;
        mem_wb.rs          <= ex_mem.rs;
        mem_wb.rt          <= ex_mem.rt;
        mem_wb.has_rt      <= ex_mem.has_rt;
        mem_wb.wr_sel      <= ex_mem.wr_sel;
        mem_wb.alu_op      <= ex_mem.alu_op;
        mem_wb.set_op      <= ex_mem.set_op;
        mem_wb.rs_data     <= ex_mem.rs_data;
        mem_wb.rt_data     <= st_data;
        mem_wb.alu_result  <= ex_mem.alu_result;
        mem_wb.set_result  <= ex_mem.set_result;
        mem_wb.lbi_result  <= ex_mem.lbi_result;
        mem_wb.slbi_result <= ex_mem.slbi_result;
        mem_wb.mem_result  <= dmem[addr];   // read every cycle, picked by SEL_MEM
    end

    // decode gives each opcode at most one memory role
    a_ld_st_excl: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.is_ld && ex_mem.is_st));

endmodule

/* verilog/core_top.sv */
/*
 * core_top
 *   four-stage pipeline top, decode through writeback
 *   stage registers, forwarding unit and writeback ports
 */
`timescale 1ns/1ps

module core_top import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     stall,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);
    logic  ex_fwd_rs;
    logic  ex_fwd_rt;
    logic  mem_fwd_rs;
    logic  mem_fwd_rt;
    logic  mem_to_mem_fwd;
    word_t ex_data;
    word_t mem_data;

    stage_if de_ex ();
    stage_if ex_mem ();
    stage_if mem_wb ();

    // writeback is the mem/wb register, its selected result comes from forward
    assign wb_valid = mem_wb.wr_en;
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_data;

    decode_stage u_decode (
        .clk, .reset, .instr_valid, .instr, .stall,
        .wb_valid, .wb_rd, .wb_data,
        .de_ex (de_ex.src)
    );

    execute_stage u_execute (
        .clk, .reset,
        .de_ex  (de_ex.dst),
        .ex_mem (ex_mem.src),
        .ex_fwd_rs, .ex_fwd_rt, .mem_fwd_rs, .mem_fwd_rt,
        .ex_data, .mem_data
    );

    memory_stage u_memory (
        .clk, .reset,
        .ex_mem (ex_mem.dst),
        .mem_wb (mem_wb.src),
        .mem_to_mem_fwd, .mem_data
    );

    forward u_forward (
        .ex_mem (ex_mem.dst),
        .mem_wb (mem_wb.dst),
        .de_ex  (de_ex.dst),
        .ex_fwd_rs, .ex_fwd_rt, .mem_fwd_rs, .mem_fwd_rt, .mem_to_mem_fwd,
        .ex_data, .mem_data
    );

endmodule

/* testbench/tb_core.sv */
/*
 * tb_core
 *   clock, reset and random instruction stimulus for core_top
 *   in-order architectural model with an expected writeback queue
 *   six tests, value compare task, cycle-count timeout
 */
`timescale 1ns/1ps

module tb_core import isa_pkg::*;;
    localparam int LEN_T1 = 204;   // 4 init + 200 chained ALU ops
    localparam int LEN_T2 = 110;
    localparam int LEN_T3 = 12;
    localparam int LEN_T4 = 5;
    localparam int LEN_T5 = 8;
    localparam int LEN_T6 = 400;
    localparam int LIMIT  = (LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6) * 2 + 50;

    logic     clk;
    logic     reset;
    logic     instr_valid;
    instr_t   instr;
    logic     stall;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    word_t    regs [8];             // architectural register file
    word_t    mem  [16];
    instr_t   prog [$];             // instructions not yet driven
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    int       cycles;
    int       errors;
    int       test_errors;
    int       stall_cnt;
    int       tests_run;

    core_top core_top_inst (
        .clk, .reset, .instr_valid, .instr, .stall, .wb_valid, .wb_rd, .wb_data
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    function automatic instr_t enc_reg(input int op, input int rd, input int rs, input int rt);
        return instr_t'({op[3:0], rd[2:0], rs[2:0], rt[2:0], 3'b000});
    endfunction

    function automatic instr_t enc_imm(input int op, input int rd, input int imm);
        return instr_t'({op[3:0], rd[2:0], 1'b0, imm[7:0]});
    endfunction

    // executes one accepted instruction in program order
    task automatic model_exec(input instr_t i);
        int    op;
        int    rd;
        int    rs;
        int    rt;
        word_t a;
        word_t b;
        word_t v;
        logic  wr;
        op = int'(i[15:12]);
        rd = int'(i[11:9]);
        rs = int'(i[8:6]);
        rt = int'(i[5:3]);
        a  = regs[rs];
        b  = regs[rt];
        wr = 1'b1;
        v  = '0;
        case (op)
            1: v = a + b;
            2: v = a - b;
            3: v = a & b;
            4: v = a ^ b;
            5: v = (a == b) ? 16'd1 : 16'd0;
            6: v = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            7: v = {{8{i[7]}}, i[7:0]};              // sign-extended immediate
            8: v = {regs[rd][7:0], i[7:0]};          // old rd shifted up by 8
            9: v = mem[a[3:0]];
            10: begin
                mem[a[3:0]] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;                      // no-op
        endcase
        if (wr) begin
            regs[rd] = v;
            exp_rd.push_back(reg_idx_t'(rd));
            exp_data.push_back(v);
        end
    endtask

    always @(posedge clk) begin : drive_and_check
        logic acc;
        acc = instr_valid && !stall;
        if (reset) begin
            instr_valid <= 1'b0;
        end else begin
            cycles++;
            if (cycles > LIMIT) begin
                $display("timeout: run did not finish within %0d cycles", LIMIT);
                $display(">>> FAIL");
                $finish;
            end else begin
                if (stall) stall_cnt++;
                if (acc) model_exec(instr);
                if (wb_valid) begin
                    if (exp_rd.size() == 0) begin
                        $display("error at %0t: writeback to r%0d with none expected",
                                 $time, wb_rd);
                        errors++;
                        test_errors++;
                    end else begin
                        check_value("wb_rd", word_t'(wb_rd), word_t'(exp_rd.pop_front()));
                        check_value("wb_data", wb_data, exp_data.pop_front());
                    end
                end
                if (instr_valid && !acc) begin
                    // held while stalled
                end else if (prog.size() != 0) begin
                    instr       <= prog.pop_front();
                    instr_valid <= 1'b1;
                end else begin
                    instr_valid <= 1'b0;
                end
            end
        end
    end

    // waits until the program is driven and every writeback has come back
    task automatic finish_test(input string name);
        while (prog.size() != 0 || instr_valid || exp_rd.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    initial begin
        int prev;
        int rd;
        int stall_before;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cycles      = 0;
        errors      = 0;
        test_errors = 0;
        stall_cnt   = 0;
        tests_run   = 0;
        for (int k = 0; k < 8; k++) regs[k] = '0;
        for (int k = 0; k < 16; k++) mem[k] = '0;
        void'($urandom(32'hc551_a658));
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // chained ALU ops, each reads the previous rd
        for (int k = 0; k < 4; k++) prog.push_back(enc_imm(7, k, int'($urandom_range(255, 0))));
        prev = 3;
        for (int k = 0; k < 200; k++) begin
            rd = int'($urandom_range(3, 0));
            prog.push_back(enc_reg(int'($urandom_range(4, 1)), rd, prev,
                                   int'($urandom_range(3, 0))));
            prev = rd;
        end
        finish_test("ex_mem forward");

        // nearer producer wins, then distance two and three
        prog.push_back(enc_imm(7, 1, 5));
        prog.push_back(enc_imm(7, 1, 9));
        prog.push_back(enc_reg(1, 2, 1, 1));     // r2 = 18
        prog.push_back(enc_imm(7, 3, 4));
        prog.push_back(enc_imm(7, 4, 1));
        prog.push_back(enc_reg(1, 5, 3, 3));     // distance two
        prog.push_back(enc_imm(7, 6, 2));
        prog.push_back(16'h0000);
        prog.push_back(16'h0000);
        prog.push_back(enc_reg(1, 7, 6, 6));     // distance three, rf bypass
        for (int k = 0; k < 100; k++) begin
            prog.push_back(enc_reg(int'($urandom_range(4, 0)), int'($urandom_range(7, 0)),
                                   int'($urandom_range(7, 0)), int'($urandom_range(7, 0))));
        end
        finish_test("mem_wb forward and bypass");

        // immediates and compares, 0x85 is negative
        prog.push_back(enc_imm(7, 0, 8'h85));
        prog.push_back(enc_imm(8, 0, 8'h12));
        prog.push_back(enc_imm(7, 1, 8'h7f));
        prog.push_back(enc_reg(6, 2, 0, 1));
        prog.push_back(enc_reg(6, 3, 1, 0));
        prog.push_back(enc_reg(5, 4, 1, 1));
        prog.push_back(enc_reg(5, 5, 0, 1));
        prog.push_back(enc_imm(7, 6, 8'hff));
        prog.push_back(enc_imm(8, 6, 8'h00));
        prog.push_back(enc_reg(6, 7, 6, 6));
        prog.push_back(enc_imm(8, 7, int'($urandom_range(255, 0))));
        prog.push_back(enc_reg(5, 7, 7, 7));
        finish_test("lbi slbi seq slt");

        // load then dependent add, exactly one stall cycle
        stall_before = stall_cnt;
        prog.push_back(enc_imm(7, 1, 3));
        prog.push_back(enc_imm(7, 2, 8'h5a));
        prog.push_back(enc_reg(10, 0, 1, 2));    // mem[3] = r2
        prog.push_back(enc_reg(9, 3, 1, 0));
        prog.push_back(enc_reg(1, 4, 3, 3));
        finish_test("load-use stall");
        check_value("stall_cycles", word_t'(stall_cnt - stall_before), 16'd1);

        // load, store of the loaded value, load it back
        prog.push_back(enc_imm(7, 1, 5));
        prog.push_back(enc_imm(7, 2, 8'hc3));
        prog.push_back(enc_imm(7, 5, 9));
        prog.push_back(enc_reg(10, 0, 1, 2));    // mem[5] = r2, nonzero
        prog.push_back(enc_reg(9, 3, 1, 0));     // r3 = mem[5]
        prog.push_back(enc_reg(10, 0, 5, 3));    // mem[9] = r3
        prog.push_back(enc_reg(9, 6, 5, 0));
        prog.push_back(enc_reg(1, 7, 6, 3));
        finish_test("store data forward");

        // mixed run, opcodes 11..15 and 0 act as no-ops
        for (int k = 0; k < 400; k++) begin
            prog.push_back(instr_t'({4'(int'($urandom_range(11, 0))), 12'($urandom)}));
        end
        finish_test("mixed random");

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_if.sv
verilog/decode_stage.sv
verilog/forward.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/core_top.sv
testbench/tb_core.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -sv --top-module tb_core -f list.f \
    --Mdir obj_dir -o sim_tb_core
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1
